// File: logic/ghtGeomPkg.sv
// **************************************************
// table geometry of the global history table
// and the index union with its bank/row/column view
// **************************************************
package ghtGeomPkg;

    localparam int IndexWidth   = 16;
    localparam int BankCount    = 8;
    localparam int BankSelWidth = 3;
    localparam int RowCount     = 32;
    localparam int RowWidth     = 5;
    localparam int ColCount     = 256;
    localparam int ColWidth     = 8;

    // bank number is {bankHi, bankLo}
    typedef struct packed {
        logic [ColWidth-1:0]       col;
        logic [BankSelWidth-2:0]   bankHi;
        logic [RowWidth-1:0]       row;
        logic                      bankLo;
    } ghtIndexFields_t;

    typedef union packed {
        logic [IndexWidth-1:0] raw;
        ghtIndexFields_t       f;
    } ghtIndex_u;

endpackage

// File: logic/ghtCtrlPkg.sv
// **************************************************
// clearing sweep constants
// **************************************************
package ghtCtrlPkg;

    // one row of every bank per sweep cycle
    localparam int ClearCycles     = ghtGeomPkg::RowCount;
    localparam int ClearCountWidth = $clog2(ClearCycles);

endpackage

// File: logic/ghtBitRam.sv
// **************************************************
// 32x256 bit-enable RAM, asynchronous read
// **************************************************
`timescale 1ns/1ps

module ghtBitRam import ghtGeomPkg::*; (
    input  logic                clk,
    input  logic [RowWidth-1:0] row,
    output logic [ColCount-1:0] rdata,
    input  logic [RowWidth-1:0] wrow,
    input  logic [ColCount-1:0] wdata,
    input  logic [ColCount-1:0] bitEn,
    input  logic                wen
);

    logic [ColCount-1:0] mem [RowCount];

    // after the edge the read already returns the new bits
    assign rdata = mem[row];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[wrow] <= (mem[wrow] & ~bitEn) | (wdata & bitEn);
        end
    end

    // the scheduler and the sweep together always define the enable
    wenKnown: assert property (@(posedge clk) !$isunknown(wen))
        else $error("ghtBitRam: write enable unknown");

endmodule

// File: logic/ghtBank.sv
// **************************************************
// one table bank: column decode, clear-all enable
// and the column read mux around the bit RAM
// **************************************************
`timescale 1ns/1ps

module ghtBank import ghtGeomPkg::*; (
    input  logic                clk,
    input  logic [RowWidth-1:0] readRow,
    input  logic [ColWidth-1:0] readCol,
    output logic                bankBit,
    input  logic                wen,
    input  logic [RowWidth-1:0] wrow,
    input  logic [ColWidth-1:0] wcol,
    input  logic                wval,
    input  logic                clearAll
);

    logic [ColCount-1:0] rdata;
    logic [ColCount-1:0] wdata;
    logic [ColCount-1:0] bitEn;
    logic                ramWen;

    // single entry update, or the whole row while sweeping
    always_comb begin
        if (clearAll) begin
            bitEn = '1;
            wdata = '0;
        end else begin
            bitEn = ColCount'(1) << wcol;
            wdata = {ColCount{wval}};
        end
    end

    assign ramWen = wen | clearAll;

    ghtBitRam ram (
        .clk   (clk),
        .row   (readRow),
        .rdata (rdata),
        .wrow  (wrow),
        .wdata (wdata),
        .bitEn (bitEn),
        .wen   (ramWen)
    );

    assign bankBit = rdata[readCol];

endmodule

// File: logic/ghtWriteSched.sv
// **************************************************
// update port routing with one-entry defer slot
// and the clearing sweep after reset
// **************************************************
`timescale 1ns/1ps

module ghtWriteSched import ghtGeomPkg::*; import ghtCtrlPkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wen0,
    input  ghtIndex_u                           addr0,
    input  logic                                val0,
    input  logic                                wen1,
    input  ghtIndex_u                           addr1,
    input  logic                                val1,
    output logic [BankCount-1:0]                bankWen,
    output logic [BankCount-1:0][RowWidth-1:0]  bankRow,
    output logic [BankCount-1:0][ColWidth-1:0]  bankCol,
    output logic [BankCount-1:0]                bankVal,
    output logic                                clearAll
);

    logic                       clearing;
    logic [ClearCountWidth-1:0] sweepCount;

    logic                       slotValid;
    ghtIndex_u                  slotIdx;
    logic                       slotVal;

    logic [BankSelWidth-1:0]    bank0;
    logic [BankSelWidth-1:0]    bank1;
    logic [BankSelWidth-1:0]    bankS;
    logic                       save0;
    logic                       save1;
    logic                       go0;
    logic                       go1;
    logic [BankCount-1:0]       slotHit;
    logic [BankCount-1:0]       port0Hit;
    logic [BankCount-1:0]       port1Hit;

    assign bank0 = {addr0.f.bankHi, addr0.f.bankLo};
    assign bank1 = {addr1.f.bankHi, addr1.f.bankLo};
    assign bankS = {slotIdx.f.bankHi, slotIdx.f.bankLo};

    // saved write first, then port 0, then port 1
    assign save0 = !clearing && slotValid && wen0 && bank0 == bankS;
    assign save1 = !clearing && wen1
        && ((wen0 && bank1 == bank0) || (slotValid && bank1 == bankS));
    assign go0   = !clearing && wen0 && !(slotValid && bank0 == bankS);
    assign go1   = !clearing && wen1 && !save1;

    assign slotHit  = (!clearing && slotValid) ? BankCount'(1) << bankS : '0;
    assign port0Hit = go0 ? BankCount'(1) << bank0 : '0;
    assign port1Hit = go1 ? BankCount'(1) << bank1 : '0;

    always_comb begin
        for (int k = 0; k < BankCount; k++) begin
            bankWen[k] = slotHit[k] | port0Hit[k] | port1Hit[k];
            bankRow[k] = sweepCount;
            bankCol[k] = '0;
            bankVal[k] = 1'b0;
            if (slotHit[k]) begin
                bankRow[k] = slotIdx.f.row;
                bankCol[k] = slotIdx.f.col;
                bankVal[k] = slotVal;
            end else if (port0Hit[k]) begin
                bankRow[k] = addr0.f.row;
                bankCol[k] = addr0.f.col;
                bankVal[k] = val0;
            end else if (port1Hit[k]) begin
                bankRow[k] = addr1.f.row;
                bankCol[k] = addr1.f.col;
                bankVal[k] = val1;
            end
        end
    end

    assign clearAll = clearing;

    always_ff @(posedge clk) begin
        if (rst) begin
            clearing   <= 1'b1;
            sweepCount <= '0;
            slotValid  <= 1'b0;
        end else begin
            if (clearing) begin
                sweepCount <= sweepCount + 1'b1;
                if (sweepCount == ClearCountWidth'(ClearCycles - 1)) begin
                    clearing <= 1'b0;
                end
            end
            slotValid <= save0 | save1;
        end
    end

    // on overflow port 0 keeps the slot and port 1 is dropped
    always_ff @(posedge clk) begin
        if (save0) begin
            slotIdx <= addr0;
            slotVal <= val0;
        end else if (save1) begin
            slotIdx <= addr1;
            slotVal <= val1;
        end
    end

    slotIdleInSweep: assert property (@(posedge clk) disable iff (rst)
        clearAll |-> !slotValid)
        else $error("ghtWriteSched: defer slot valid during sweep");

    onePortPerBank: assert property (@(posedge clk) disable iff (rst)
        (port0Hit & port1Hit) == '0)
        else $error("ghtWriteSched: both ports hit one bank");

endmodule

// File: logic/ghtLookup.sv
// **************************************************
// lookup stage: hashed index register, valid strobe
// and selection of the bank bit
// **************************************************
`timescale 1ns/1ps

module ghtLookup import ghtGeomPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  readEn,
    input  logic [IndexWidth-1:0] ipBits,
    input  logic [IndexWidth-1:0] history,
    output logic [RowWidth-1:0]   readRow,
    output logic [ColWidth-1:0]   readCol,
    input  logic [BankCount-1:0]  bankBits,
    output logic                  pred,
    output logic                  predValid
);

    ghtIndex_u readIdx;

    // index holds while readEn is low
    always_ff @(posedge clk) begin
        if (readEn) begin
            readIdx.raw <= ipBits ^ history;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else begin
            predValid <= readEn;
        end
    end

    assign readRow = readIdx.f.row;
    assign readCol = readIdx.f.col;
    assign pred    = bankBits[{readIdx.f.bankHi, readIdx.f.bankLo}];

    noValidAfterReset: assert property (@(posedge clk) rst |=> !predValid)
        else $error("ghtLookup: predValid high after reset");

endmodule

// File: logic/ghtTop.sv
// **************************************************
// global history table top: scheduler, lookup, banks
// **************************************************
`timescale 1ns/1ps

module ghtTop import ghtGeomPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  readEn,
    input  logic [IndexWidth-1:0] ipBits,
    input  logic [IndexWidth-1:0] history,
    output logic                  pred,
    output logic                  predValid,
    input  logic                  wen0,
    input  ghtIndex_u             addr0,
    input  logic                  val0,
    input  logic                  wen1,
    input  ghtIndex_u             addr1,
    input  logic                  val1
);

    logic [BankCount-1:0]               bankWen;
    logic [BankCount-1:0][RowWidth-1:0] bankRow;
    logic [BankCount-1:0][ColWidth-1:0] bankCol;
    logic [BankCount-1:0]               bankVal;
    logic                               clearAll;
    logic [RowWidth-1:0]                readRow;
    logic [ColWidth-1:0]                readCol;
    logic [BankCount-1:0]               bankBits;

    ghtWriteSched sched (
        .clk      (clk),
        .rst      (rst),
        .wen0     (wen0),
        .addr0    (addr0),
        .val0     (val0),
        .wen1     (wen1),
        .addr1    (addr1),
        .val1     (val1),
        .bankWen  (bankWen),
        .bankRow  (bankRow),
        .bankCol  (bankCol),
        .bankVal  (bankVal),
        .clearAll (clearAll)
    );

    ghtLookup lookup (
        .clk       (clk),
        .rst       (rst),
        .readEn    (readEn),
        .ipBits    (ipBits),
        .history   (history),
        .readRow   (readRow),
        .readCol   (readCol),
        .bankBits  (bankBits),
        .pred      (pred),
        .predValid (predValid)
    );

    for (genvar k = 0; k < BankCount; k++) begin : banks
        ghtBank bank (
            .clk      (clk),
            .readRow  (readRow),
            .readCol  (readCol),
            .bankBit  (bankBits[k]),
            .wen      (bankWen[k]),
            .wrow     (bankRow[k]),
            .wcol     (bankCol[k]),
            .wval     (bankVal[k]),
            .clearAll (clearAll)
        );
    end

endmodule

// File: test/ghtTb.sv
// **************************************************
// testbench for the global history table: stimulus
// file reader, compare tasks, LFSR and watchdog
// **************************************************
`timescale 1ns/1ps

module ghtTb import ghtGeomPkg::*; import ghtCtrlPkg::*; ();

    localparam int ClkPeriod = 20;
    localparam int ResetCycles = 4;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  readEn;
    logic [IndexWidth-1:0] ipBits;
    logic [IndexWidth-1:0] history;
    logic                  pred;
    logic                  predValid;
    logic                  wen0;
    ghtIndex_u             addr0;
    logic                  val0;
    logic                  wen1;
    ghtIndex_u             addr1;
    logic                  val1;

    string       stimLines[$];
    logic [31:0] lfsrState;
    int          budgetCycles = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          testChecks = 0;
    int          testErrors = 0;

    ghtTop i_dut (
        .clk       (clk),
        .rst       (rst),
        .readEn    (readEn),
        .ipBits    (ipBits),
        .history   (history),
        .pred      (pred),
        .predValid (predValid),
        .wen0      (wen0),
        .addr0     (addr0),
        .val0      (val0),
        .wen1      (wen1),
        .addr1     (addr1),
        .val1      (val1)
    );

    initial begin
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    task automatic checkPred(input logic got, input logic exp);
        checks++;
        testChecks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("FAIL %0t pred got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic checkValid(input logic got, input logic exp);
        checks++;
        testChecks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("FAIL %0t predValid got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic idleInputs();
        readEn = 1'b0;
        wen0   = 1'b0;
        wen1   = 1'b0;
    endtask

    // reset, then wait out the clearing sweep
    task automatic resetDut();
        idleInputs();
        rst = 1'b1;
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        repeat (ClearCycles + 1) @(negedge clk);
    endtask

    task automatic readOp(input logic [15:0] ip, input logic [15:0] hist, input logic exp);
        idleInputs();
        readEn  = 1'b1;
        ipBits  = ip;
        history = hist;
        @(negedge clk);
        checkPred(pred, exp);
        checkValid(predValid, 1'b1);
    endtask

    task automatic randomClearCheck(input logic doReset, input int count);
        logic [15:0] ip;
        logic [15:0] hist;
        if (doReset) begin
            resetDut();
        end
        for (int k = 0; k < count; k++) begin
            takeBits(16, ip);
            takeBits(16, hist);
            readOp(ip, hist, 1'b0);
        end
    endtask

    task automatic badLine(input string line);
        errors++;
        testErrors++;
        $display("malformed stimulus line: %s", line);
    endtask

    task automatic runLine(input string line);
        string       op;
        string       name;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] d;
        logic [15:0] e;
        logic [15:0] g;
        int          count;
        int          n;
        n = $sscanf(line, "%s", op);
        if (op == "W") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h", op, a, b, c, d, e, g);
            if (n != 7) begin
                badLine(line);
            end else begin
                idleInputs();
                wen0      = a[0];
                addr0.raw = b;
                val0      = c[0];
                wen1      = d[0];
                addr1.raw = e;
                val1      = g[0];
                @(negedge clk);
            end
        end else if (op == "R") begin
            n = $sscanf(line, "%s %h %h %h", op, a, b, c);
            if (n != 4) begin
                badLine(line);
            end else begin
                readOp(a, b, c[0]);
            end
        end else if (op == "I") begin
            idleInputs();
            @(negedge clk);
            checkValid(predValid, 1'b0);
        end else if (op == "C") begin
            n = $sscanf(line, "%s %h %d", op, a, count);
            if (n != 3) begin
                badLine(line);
            end else begin
                randomClearCheck(a[0], count);
            end
        end else if (op == "T") begin
            n = $sscanf(line, "%s %s", op, name);
            tests++;
            $display("test %s: %0d checks, %0d errors, %s", name, testChecks, testErrors,
                     (testErrors == 0) ? "passed" : "failed");
            testChecks = 0;
            testErrors = 0;
        end else begin
            badLine(line);
        end
    endtask

    task automatic loadStim(output logic ok);
        string line;
        int    fd;
        int    n;
        fd = $fopen("test/ghtStim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    stimLines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // one cycle per line plus the reset, sweep and lookups of each C line
    function automatic int stimCycles();
        string op;
        int    doReset;
        int    count;
        int    n;
        int    total;
        total = stimLines.size() + ClearCycles + 20 + ResetCycles + ClearCycles + 1;
        foreach (stimLines[k]) begin
            n = $sscanf(stimLines[k], "%s %d %d", op, doReset, count);
            if (op == "C" && n == 3) begin
                total += count + ResetCycles + ClearCycles + 1;
            end
        end
        return total;
    endfunction

    initial begin
        wait (budgetCycles != 0);
        #(budgetCycles * ClkPeriod);
        $display("timeout: stimulus did not finish within %0d cycles", budgetCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic ok;
        rst       = 1'b1;
        readEn    = 1'b0;
        ipBits    = '0;
        history   = '0;
        wen0      = 1'b0;
        addr0.raw = '0;
        val0      = 1'b0;
        wen1      = 1'b0;
        addr1.raw = '0;
        val1      = 1'b0;
        lfsrState = 32'hb08;
        loadStim(ok);
        if (!ok) begin
            errors++;
            $display("cannot open stimulus file test/ghtStim.txt");
        end else begin
            budgetCycles = stimCycles();
            resetDut();
            foreach (stimLines[k]) begin
                runLine(stimLines[k]);
            end
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: test/ghtStim.txt
# W: wen0 addr0 val0 wen1 addr1 val1 | R: ipBits history expectedPred (hex)
# I: idle cycle | C: doReset randomLookups (decimal) | T: test name
C 0 64
T clearedAfterReset
W 1 1234 1 0 0000 0
W 0 0000 0 1 56C3 1
R 1234 0000 1
R 0000 56C3 1
R 1334 0000 0
R 0000 57C3 0
T separatePorts
W 1 2040 1 1 2140 1
I
R 2040 0000 1
R 2140 0000 1
T sameBankDefer
W 1 A5A5 1 0 0000 0
R FFFF 5A5A 1
R A500 00A5 1
R 1234 B791 1
R FFFF 5A5B 0
T indexHash
I
R 0000 A5A5 1
I
I
R 0000 1334 0
T readEnable
C 1 16
R 1234 0000 0
R 0000 56C3 0
R 2040 0000 0
R A5A5 0000 0
T resetMidRun

// File: verilog.f
logic/ghtGeomPkg.sv
logic/ghtCtrlPkg.sv
logic/ghtBitRam.sv
logic/ghtBank.sv
logic/ghtWriteSched.sv
logic/ghtLookup.sv
logic/ghtTop.sv
test/ghtTb.sv

// File: run.sh
#!/bin/sh
# build and run the global history table testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module ghtTb -o ghtSim &&
./obj_dir/ghtSim | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
